// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_LINE ?= STATUS: PASS

SOURCES := $(wildcard verilog/*.sv verilog/*.svh test/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_LINE)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sources.f ====
+incdir+verilog
verilog/core_pkg.sv
verilog/regfile_if.sv
verilog/pipe_reg.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/core_top.sv
test/tb_checker.sv
test/tb_top.sv

// ==== test/tb_checker.sv ====
// Watches DUT ports only; the model updates at acceptance since records retire in order
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module tb_checker (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        instr_valid_i,
    input  logic [`CORE_INSTR_W-1:0]    instr_i,
    input  logic                        instr_ready_i,
    input  logic                        commit_valid_i,
    input  logic                        commit_ready_i,
    input  logic [`CORE_REG_ADDR_W-1:0] commit_rd_i,
    input  logic [`CORE_XLEN-1:0]       commit_data_i,
    input  logic                        commit_we_i,
    input  logic                        commit_illegal_i,
    output int unsigned                 error_count_o,
    output int unsigned                 accepted_count_o,
    output int unsigned                 committed_count_o,
    output int unsigned                 outstanding_o
);

    typedef struct packed {
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic [`CORE_XLEN-1:0]       data;
        logic                        we;
        logic                        illegal;
    } record_t;

    logic [`CORE_XLEN-1:0] model_regs [`CORE_NR_REGS];
    record_t               expect_q [$];
    record_t               held;
    logic                  held_valid = 1'b0;
    int unsigned           errors     = 0;
    int unsigned           accepted   = 0;
    int unsigned           committed  = 0;

    // ------------------------------
    // RV32I reference for OP and OP-IMM
    // ------------------------------
    function automatic record_t predict(input logic [`CORE_INSTR_W-1:0] w);
        record_t               rec;
        logic [`CORE_XLEN-1:0] a;
        logic [`CORE_XLEN-1:0] b;
        logic [`CORE_XLEN-1:0] res;
        logic                  bad;
        logic                  is_reg;
        is_reg = (w[6:0] == 7'h33);
        a      = model_regs[w[19:15]];
        b      = is_reg ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        res    = '0;
        bad    = 1'b0;
        if (is_reg || w[6:0] == 7'h13) begin
            // Shift amount is the low five bits of b, rs2 or the shamt field
            case (w[14:12])
                3'd0: res = (is_reg && w[30]) ? a - b : a + b;
                3'd1: res = a << b[4:0];
                3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: res = (a < b) ? 32'd1 : 32'd0;
                3'd4: res = a ^ b;
                3'd5: begin
                    if (w[30]) res = $signed(a) >>> b[4:0];
                    else res = a >> b[4:0];
                end
                3'd6: res = a | b;
                default: res = a & b;
            endcase
            if (is_reg) begin
                bad = !(w[31:25] == 7'h00 ||
                        (w[31:25] == 7'h20 && (w[14:12] == 3'd0 || w[14:12] == 3'd5)));
            end else if (w[14:12] == 3'd1) begin
                bad = (w[31:25] != 7'h00);
            end else if (w[14:12] == 3'd5) begin
                bad = (w[31:25] != 7'h00) && (w[31:25] != 7'h20);
            end
        end else begin
            bad = 1'b1;
        end
        rec.rd      = w[11:7];
        rec.illegal = bad;
        rec.we      = !bad && (w[11:7] != 5'd0);
        rec.data    = bad ? '0 : res;
        return rec;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("MISMATCH time=%0t %s got=0x%08h expected=0x%08h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic check_record(input string tag, input record_t want);
        check_field({"commit_rd_o", tag}, 32'(commit_rd_i), 32'(want.rd));
        check_field({"commit_data_o", tag}, commit_data_i, want.data);
        check_field({"commit_we_o", tag}, 32'(commit_we_i), 32'(want.we));
        check_field({"commit_illegal_o", tag}, 32'(commit_illegal_i), 32'(want.illegal));
    endtask

    always @(posedge clk_i or negedge rst_ni) begin : watch
        record_t rec;
        if (!rst_ni) begin
            for (int i = 0; i < `CORE_NR_REGS; i++) begin
                model_regs[i] = '0;
            end
            expect_q.delete();
            held_valid = 1'b0;
        end else begin
            // Empty pipeline and no pending write, so decode must be ready
            if (expect_q.size() == 0) begin
                check_field("instr_ready_o", 32'(instr_ready_i), 32'd1);
            end
            // A record not taken must stay valid and unchanged
            if (held_valid) begin
                if (!commit_valid_i) begin
                    $display("ERROR time=%0t commit_valid_o fell before the record was taken",
                             $time);
                    errors++;
                end else begin
                    check_record(" (held)", held);
                end
            end
            if (commit_valid_i && expect_q.size() == 0) begin
                $display("ERROR time=%0t commit_valid_o high with no instruction in flight",
                         $time);
                errors++;
            end else if (commit_valid_i && commit_ready_i) begin
                rec = expect_q.pop_front();
                check_record("", rec);
                committed++;
            end
            held_valid = commit_valid_i && !commit_ready_i;
            held       = {commit_rd_i, commit_data_i, commit_we_i, commit_illegal_i};

            if (instr_valid_i && instr_ready_i) begin
                rec = predict(instr_i);
                if (rec.we) begin
                    model_regs[rec.rd] = rec.data;
                end
                expect_q.push_back(rec);
                accepted++;
            end
        end
        error_count_o     <= errors;
        accepted_count_o  <= accepted;
        committed_count_o <= committed;
        outstanding_o     <= $unsigned(expect_q.size());
    end

endmodule

`default_nettype wire

// ==== test/tb_top.sv ====
// Table rows run in order; commit_ready_i is random from a fixed seed, so every run repeats
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module tb_top;

    localparam int          CLK_PERIOD     = 40;
    localparam int          RESET_CYCLES   = 8;
    localparam int          TIMEOUT_CYCLES = 200;
    localparam logic [31:0] SEED           = 32'h5450;

    // Idle cycles ahead of the word, then the word
    typedef struct packed {
        logic [7:0]               gap;
        logic [`CORE_INSTR_W-1:0] instr;
    } entry_t;

    logic                        clk_i;
    logic                        rst_ni;
    logic                        instr_valid_i;
    logic [`CORE_INSTR_W-1:0]    instr_i;
    logic                        instr_ready_o;
    logic                        commit_valid_o;
    logic                        commit_ready_i;
    logic [`CORE_REG_ADDR_W-1:0] commit_rd_o;
    logic [`CORE_XLEN-1:0]       commit_data_o;
    logic                        commit_we_o;
    logic                        commit_illegal_o;
    int unsigned                 error_count;
    int unsigned                 accepted_count;
    int unsigned                 committed_count;
    int unsigned                 outstanding;
    entry_t                      table_q [$];

    core_top u_dut (.*);

    tb_checker u_checker (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .instr_valid_i     (instr_valid_i),
        .instr_i           (instr_i),
        .instr_ready_i     (instr_ready_o),
        .commit_valid_i    (commit_valid_o),
        .commit_ready_i    (commit_ready_i),
        .commit_rd_i       (commit_rd_o),
        .commit_data_i     (commit_data_o),
        .commit_we_i       (commit_we_o),
        .commit_illegal_i  (commit_illegal_o),
        .error_count_o     (error_count),
        .accepted_count_o  (accepted_count),
        .committed_count_o (committed_count),
        .outstanding_o     (outstanding)
    );

    function automatic logic [31:0] op_imm(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] op_reg(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic void add_row(input logic [7:0] gap, input logic [31:0] instr);
        entry_t row;
        row.gap   = gap;
        row.instr = instr;
        table_q.push_back(row);
    endfunction

    // ------------------------------
    // Stimulus table
    // ------------------------------
    function automatic void load_table();
        // Immediates on x1 = -5 and x2 = 100
        add_row(8'd0, op_imm(3'd0, 5'd1, 5'd0, 12'hFFB));
        add_row(8'd0, op_imm(3'd0, 5'd2, 5'd0, 12'h064));
        add_row(8'd1, op_imm(3'd0, 5'd3, 5'd1, 12'h800));
        add_row(8'd0, op_imm(3'd2, 5'd4, 5'd1, 12'h000));
        add_row(8'd0, op_imm(3'd3, 5'd6, 5'd2, 12'hFFF));
        add_row(8'd0, op_imm(3'd4, 5'd8, 5'd1, 12'hFFF));
        add_row(8'd0, op_imm(3'd6, 5'd9, 5'd2, 12'h7F0));
        add_row(8'd2, op_imm(3'd7, 5'd10, 5'd1, 12'h0F0));
        add_row(8'd0, op_imm(3'd1, 5'd11, 5'd2, 12'h007));
        add_row(8'd0, op_imm(3'd5, 5'd12, 5'd1, 12'h01C));
        add_row(8'd0, op_imm(3'd5, 5'd13, 5'd3, 12'h41F));
        // Register forms on the values above
        add_row(8'd0, op_reg(7'h00, 3'd0, 5'd15, 5'd1, 5'd2));
        add_row(8'd0, op_reg(7'h20, 3'd0, 5'd16, 5'd1, 5'd2));
        add_row(8'd0, op_reg(7'h00, 3'd1, 5'd17, 5'd2, 5'd8));
        add_row(8'd0, op_reg(7'h00, 3'd2, 5'd18, 5'd1, 5'd2));
        add_row(8'd0, op_reg(7'h00, 3'd3, 5'd19, 5'd1, 5'd2));
        add_row(8'd0, op_reg(7'h00, 3'd4, 5'd20, 5'd1, 5'd9));
        add_row(8'd0, op_reg(7'h00, 3'd5, 5'd21, 5'd1, 5'd8));
        add_row(8'd0, op_reg(7'h20, 3'd5, 5'd22, 5'd1, 5'd8));
        add_row(8'd0, op_reg(7'h00, 3'd6, 5'd23, 5'd10, 5'd11));
        add_row(8'd0, op_reg(7'h00, 3'd7, 5'd24, 5'd1, 5'd9));
        // RAW and WAW chain on x25
        add_row(8'd0, op_imm(3'd0, 5'd25, 5'd0, 12'h001));
        add_row(8'd0, op_reg(7'h00, 3'd0, 5'd25, 5'd25, 5'd25));
        add_row(8'd0, op_reg(7'h00, 3'd0, 5'd25, 5'd25, 5'd25));
        add_row(8'd0, op_imm(3'd0, 5'd26, 5'd25, 12'h003));
        add_row(8'd0, op_reg(7'h20, 3'd0, 5'd27, 5'd26, 5'd25));
        add_row(8'd0, op_reg(7'h00, 3'd0, 5'd25, 5'd27, 5'd26));
        // Illegal words, then x0 as a target and as a source
        add_row(8'd1, 32'h0000_0000);
        add_row(8'd0, 32'hFFFF_FFFF);
        add_row(8'd0, op_imm(3'd1, 5'd4, 5'd1, 12'h405));
        add_row(8'd0, op_imm(3'd5, 5'd6, 5'd1, 12'h205));
        add_row(8'd0, op_reg(7'h01, 3'd0, 5'd8, 5'd1, 5'd2));
        add_row(8'd0, op_imm(3'd0, 5'd0, 5'd1, 12'h007));
        add_row(8'd0, op_reg(7'h00, 3'd0, 5'd28, 5'd0, 5'd4));
        add_row(8'd0, op_reg(7'h20, 3'd0, 5'd29, 5'd0, 5'd6));
        add_row(8'd0, op_imm(3'd0, 5'd30, 5'd8, 12'h000));
        // x5 and x7 are never written, so they still hold their reset zero
        add_row(8'd0, op_reg(7'h00, 3'd6, 5'd31, 5'd5, 5'd7));
    endfunction

    // Presents one row and waits for the handshake
    task automatic drive_entry(input entry_t row, output bit timed_out);
        int waited;
        waited = 0;
        repeat (row.gap) begin
            instr_valid_i <= 1'b0;
            @(posedge clk_i);
        end
        instr_valid_i <= 1'b1;
        instr_i       <= row.instr;
        do begin
            @(posedge clk_i);
            waited++;
        end while (!instr_ready_o && waited < TIMEOUT_CYCLES);
        timed_out = !instr_ready_o;
    endtask

    initial begin : clock_gen
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    always @(posedge clk_i) begin : ready_drive
        commit_ready_i <= ($urandom % 3) != 0;
    end

    initial begin : stimulus
        bit          timed_out;
        int          waited;
        timed_out      = 1'b0;
        waited         = 0;
        void'($urandom(SEED));
        rst_ni         = 1'b0;
        instr_valid_i  = 1'b0;
        instr_i        = '0;
        commit_ready_i = 1'b0;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        // Idle after reset, no commit may show up here
        repeat (4) @(posedge clk_i);

        for (int i = 0; i < table_q.size() && !timed_out; i++) begin
            drive_entry(table_q[i], timed_out);
        end
        instr_valid_i <= 1'b0;

        if (timed_out) begin
            $display("Timeout: instr_ready_o stayed low for %0d cycles", TIMEOUT_CYCLES);
        end else begin
            do begin
                @(posedge clk_i);
                waited++;
            end while ((outstanding != 0 || accepted_count != table_q.size()) &&
                       waited < TIMEOUT_CYCLES);
            if (outstanding != 0 || accepted_count != table_q.size()) begin
                $display("Timeout: %0d accepted instructions never committed", outstanding);
                timed_out = 1'b1;
            end
        end

        repeat (2) @(posedge clk_i);
        $display("accepted=%0d committed=%0d errors=%0d",
                 accepted_count, committed_count, error_count);
        if (timed_out || error_count != 0) begin
            $display("STATUS: FAIL");
        end else begin
            $display("STATUS: PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/core_pkg.sv ====
// Types for the integer pipeline; only OP and OP-IMM encodings are covered here
`default_nettype none

`include "core_settings.svh"

package core_pkg;

    // ------------------------------
    // ALU operations
    // ------------------------------
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // ------------------------------
    // Major opcodes
    // ------------------------------
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

    // ------------------------------
    // Stage payloads
    // ------------------------------

    // Decode to execute, operands already read
    typedef struct packed {
        alu_op_e                     alu_op;
        logic [`CORE_XLEN-1:0]       operand_a;
        logic [`CORE_XLEN-1:0]       operand_b;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic                        we;
        logic                        illegal;
    } decoded_op_t;

    // Execute to writeback
    typedef struct packed {
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic [`CORE_XLEN-1:0]       data;
        logic                        we;
        logic                        illegal;
    } result_t;

endpackage

`default_nettype wire

// ==== verilog/core_settings.svh ====
// Core widths for RV32I only; CORE_REG_ADDR_W must equal $clog2(CORE_NR_REGS)
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data path width
`define CORE_XLEN 32

// Architectural register file
`define CORE_NR_REGS 32
`define CORE_REG_ADDR_W 5

// Fetched instruction word, no compressed encodings
`define CORE_INSTR_W 32

`endif

// ==== verilog/core_top.sv ====
// In-order RV32I integer pipeline, two-cycle latency; no fetch, memory, CSR or traps
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module core_top (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        instr_valid_i,
    input  logic [`CORE_INSTR_W-1:0]    instr_i,
    output logic                        instr_ready_o,
    output logic                        commit_valid_o,
    input  logic                        commit_ready_i,
    output logic [`CORE_REG_ADDR_W-1:0] commit_rd_o,
    output logic [`CORE_XLEN-1:0]       commit_data_o,
    output logic                        commit_we_o,
    output logic                        commit_illegal_o
);

    // ------------------------------
    // Stage wires
    // ------------------------------
    logic                  dec_valid;
    core_pkg::decoded_op_t dec_op;
    logic                  dec_ready;

    logic                  ex_in_valid;
    core_pkg::decoded_op_t ex_in_op;
    logic                  ex_in_ready;

    logic                  ex_valid;
    core_pkg::result_t     ex_res;
    logic                  ex_ready;

    logic                  wb_valid;
    core_pkg::result_t     wb_res;
    logic                  wb_ready;

    regfile_if u_rf_if ();

    decode_stage u_decode (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_ready_o (instr_ready_o),
        .op_valid_o    (dec_valid),
        .op_o          (dec_op),
        .op_ready_i    (dec_ready),
        .rf            (u_rf_if.dec)
    );

    pipe_reg #(
        .T (core_pkg::decoded_op_t)
    ) u_dec_reg (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .valid_i (dec_valid),
        .data_i  (dec_op),
        .ready_o (dec_ready),
        .valid_o (ex_in_valid),
        .data_o  (ex_in_op),
        .ready_i (ex_in_ready)
    );

    execute_stage u_execute (
        .op_valid_i  (ex_in_valid),
        .op_i        (ex_in_op),
        .op_ready_o  (ex_in_ready),
        .res_valid_o (ex_valid),
        .res_o       (ex_res),
        .res_ready_i (ex_ready)
    );

    pipe_reg #(
        .T (core_pkg::result_t)
    ) u_ex_reg (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .valid_i (ex_valid),
        .data_i  (ex_res),
        .ready_o (ex_ready),
        .valid_o (wb_valid),
        .data_o  (wb_res),
        .ready_i (wb_ready)
    );

    writeback_stage u_writeback (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .res_valid_i      (wb_valid),
        .res_i            (wb_res),
        .res_ready_o      (wb_ready),
        .commit_valid_o   (commit_valid_o),
        .commit_ready_i   (commit_ready_i),
        .commit_rd_o      (commit_rd_o),
        .commit_data_o    (commit_data_o),
        .commit_we_o      (commit_we_o),
        .commit_illegal_o (commit_illegal_o),
        .rf               (u_rf_if.wb)
    );

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
// RV32I OP/OP-IMM decode only; one pending write per register, stalls on any RAW/WAW
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module decode_stage (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     instr_valid_i,
    input  logic [`CORE_INSTR_W-1:0] instr_i,
    output logic                     instr_ready_o,
    output logic                     op_valid_o,
    output core_pkg::decoded_op_t    op_o,
    input  logic                     op_ready_i,
    regfile_if.dec                   rf
);

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;
    localparam int unsigned SHAMT_W    = $clog2(`CORE_XLEN);

    logic [6:0]                  opcode;
    logic [2:0]                  funct3;
    logic [6:0]                  funct7;
    logic [`CORE_REG_ADDR_W-1:0] rs1;
    logic [`CORE_REG_ADDR_W-1:0] rs2;
    logic [`CORE_REG_ADDR_W-1:0] rd;
    logic                        is_op;
    logic                        is_op_imm;
    logic                        illegal;
    logic                        we;
    core_pkg::alu_op_e           alu_op;
    logic [`CORE_XLEN-1:0]       imm;
    logic [`CORE_NR_REGS-1:0]    pending_q;
    logic [`CORE_NR_REGS-1:0]    busy;
    logic [`CORE_NR_REGS-1:0]    clr_mask;
    logic [`CORE_NR_REGS-1:0]    set_mask;
    logic                        stall;
    logic                        issue;

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign funct7    = instr_i[31:25];
    assign rd        = instr_i[11:7];
    assign rs1       = instr_i[19:15];
    assign rs2       = instr_i[24:20];
    assign is_op     = (opcode == core_pkg::OPCODE_OP);
    assign is_op_imm = (opcode == core_pkg::OPCODE_OP_IMM);

    // ------------------------------
    // Field decode
    // ------------------------------
    always_comb begin : field_decode
        alu_op  = core_pkg::ALU_ADD;
        illegal = 1'b0;
        imm     = {{(`CORE_XLEN-12){instr_i[31]}}, instr_i[31:20]};
        if (is_op) begin
            case ({funct7, funct3})
                {FUNCT7_BASE, 3'b000}: alu_op = core_pkg::ALU_ADD;
                {FUNCT7_ALT,  3'b000}: alu_op = core_pkg::ALU_SUB;
                {FUNCT7_BASE, 3'b001}: alu_op = core_pkg::ALU_SLL;
                {FUNCT7_BASE, 3'b010}: alu_op = core_pkg::ALU_SLT;
                {FUNCT7_BASE, 3'b011}: alu_op = core_pkg::ALU_SLTU;
                {FUNCT7_BASE, 3'b100}: alu_op = core_pkg::ALU_XOR;
                {FUNCT7_BASE, 3'b101}: alu_op = core_pkg::ALU_SRL;
                {FUNCT7_ALT,  3'b101}: alu_op = core_pkg::ALU_SRA;
                {FUNCT7_BASE, 3'b110}: alu_op = core_pkg::ALU_OR;
                {FUNCT7_BASE, 3'b111}: alu_op = core_pkg::ALU_AND;
                default:               illegal = 1'b1;
            endcase
        end else if (is_op_imm) begin
            case (funct3)
                3'b000: alu_op = core_pkg::ALU_ADD;
                3'b010: alu_op = core_pkg::ALU_SLT;
                3'b011: alu_op = core_pkg::ALU_SLTU;
                3'b100: alu_op = core_pkg::ALU_XOR;
                3'b110: alu_op = core_pkg::ALU_OR;
                3'b111: alu_op = core_pkg::ALU_AND;
                3'b001: begin
                    alu_op  = core_pkg::ALU_SLL;
                    illegal = (funct7 != FUNCT7_BASE);
                end
                default: begin
                    // funct3 101 picks logical or arithmetic right shift
                    alu_op  = (funct7 == FUNCT7_ALT) ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
                    illegal = (funct7 != FUNCT7_BASE) && (funct7 != FUNCT7_ALT);
                end
            endcase
            if (funct3 == 3'b001 || funct3 == 3'b101) begin
                imm = {{(`CORE_XLEN-SHAMT_W){1'b0}}, instr_i[20 +: SHAMT_W]};
            end
        end else begin
            illegal = 1'b1;
        end
    end

    // x0 and illegal words never reach the register file
    assign we = !illegal && (rd != '0);

    // ------------------------------
    // Pending writes and stall
    // ------------------------------
    always_comb begin : pending_masks
        clr_mask = '0;
        set_mask = '0;
        if (rf.wr_en) begin
            clr_mask[rf.wr_addr] = 1'b1;
        end
        if (issue && we) begin
            set_mask[rd] = 1'b1;
        end
    end

    // A write committing this cycle is bypassed, so it no longer blocks
    assign busy = pending_q & ~clr_mask;

    assign stall = instr_valid_i && !illegal &&
                   (busy[rs1] || (is_op && busy[rs2]) || (we && busy[rd]));

    assign instr_ready_o = op_ready_i && !stall;
    assign issue         = instr_valid_i && instr_ready_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= '0;
        end else begin
            pending_q <= busy | set_mask;
        end
    end

    // ------------------------------
    // Operand read and output
    // ------------------------------
    assign rf.rs1_addr = rs1;
    assign rf.rs2_addr = rs2;

    assign op_valid_o        = instr_valid_i && !stall;
    assign op_o.alu_op       = alu_op;
    assign op_o.operand_a    = rf.rs1_data;
    assign op_o.operand_b    = is_op ? rf.rs2_data : imm;
    assign op_o.rd           = rd;
    assign op_o.we           = we;
    assign op_o.illegal      = illegal;

endmodule

`default_nettype wire

// ==== verilog/execute_stage.sv ====
// Single-cycle integer ALU, no multiply or divide; handshake passes straight through
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module execute_stage (
    input  logic                  op_valid_i,
    input  core_pkg::decoded_op_t op_i,
    output logic                  op_ready_o,
    output logic                  res_valid_o,
    output core_pkg::result_t     res_o,
    input  logic                  res_ready_i
);

    localparam int unsigned SHAMT_W = $clog2(`CORE_XLEN);

    logic [`CORE_XLEN-1:0] a;
    logic [`CORE_XLEN-1:0] b;
    logic [SHAMT_W-1:0]    shamt;
    logic [`CORE_XLEN-1:0] result;

    assign a     = op_i.operand_a;
    assign b     = op_i.operand_b;
    assign shamt = b[SHAMT_W-1:0];

    always_comb begin : alu
        case (op_i.alu_op)
            core_pkg::ALU_ADD:  result = a + b;
            core_pkg::ALU_SUB:  result = a - b;
            core_pkg::ALU_SLL:  result = a << shamt;
            core_pkg::ALU_SLT:  result = {{(`CORE_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            core_pkg::ALU_SLTU: result = {{(`CORE_XLEN-1){1'b0}}, a < b};
            core_pkg::ALU_XOR:  result = a ^ b;
            core_pkg::ALU_SRL:  result = a >> shamt;
            core_pkg::ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
            core_pkg::ALU_OR:   result = a | b;
            core_pkg::ALU_AND:  result = a & b;
            default:            result = '0;
        endcase
    end

    // Illegal words carry no data
    assign res_o.rd      = op_i.rd;
    assign res_o.data    = op_i.illegal ? '0 : result;
    assign res_o.we      = op_i.we;
    assign res_o.illegal = op_i.illegal;

    assign res_valid_o = op_valid_i;
    assign op_ready_o  = res_ready_i;

endmodule

`default_nettype wire

// ==== verilog/pipe_reg.sv ====
// One-entry register slice; ready_o combinationally follows ready_i when full
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic valid_i,
    input  T     data_i,
    output logic ready_o,
    output logic valid_o,
    output T     data_o,
    input  logic ready_i
);

    logic valid_q;
    T     data_q;

    // Free slot, or the held item leaves this cycle
    assign ready_o = !valid_q || ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ready_o && valid_i) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

`default_nettype wire

// ==== verilog/regfile_if.sv ====
// Two read ports and one write port; write signals double as the hazard clear
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

interface regfile_if;

    // Read side, addresses from decode
    logic [`CORE_REG_ADDR_W-1:0] rs1_addr;
    logic [`CORE_REG_ADDR_W-1:0] rs2_addr;
    logic [`CORE_XLEN-1:0]       rs1_data;
    logic [`CORE_XLEN-1:0]       rs2_data;

    // Write side, one write per committed record
    logic                        wr_en;
    logic [`CORE_REG_ADDR_W-1:0] wr_addr;
    logic [`CORE_XLEN-1:0]       wr_data;

    modport dec (
        output rs1_addr, rs2_addr,
        input  rs1_data, rs2_data,
        input  wr_en, wr_addr, wr_data
    );

    modport wb (
        input  rs1_addr, rs2_addr,
        output rs1_data, rs2_data,
        output wr_en, wr_addr, wr_data
    );

endinterface

`default_nettype wire

// ==== verilog/writeback_stage.sv ====
// Flop-based register file with write-to-read bypass; writes only on the commit handshake
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module writeback_stage (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        res_valid_i,
    input  core_pkg::result_t           res_i,
    output logic                        res_ready_o,
    output logic                        commit_valid_o,
    input  logic                        commit_ready_i,
    output logic [`CORE_REG_ADDR_W-1:0] commit_rd_o,
    output logic [`CORE_XLEN-1:0]       commit_data_o,
    output logic                        commit_we_o,
    output logic                        commit_illegal_o,
    regfile_if.wb                       rf
);

    logic [`CORE_XLEN-1:0] regs_q [`CORE_NR_REGS];
    logic                  commit_fire;

    // ------------------------------
    // Commit handshake
    // ------------------------------
    assign commit_valid_o   = res_valid_i;
    assign res_ready_o      = commit_ready_i;
    assign commit_rd_o      = res_i.rd;
    assign commit_data_o    = res_i.data;
    assign commit_we_o      = res_i.we;
    assign commit_illegal_o = res_i.illegal;

    assign commit_fire = res_valid_i && commit_ready_i;

    // Also seen by decode to release the pending bit
    assign rf.wr_en   = commit_fire && res_i.we;
    assign rf.wr_addr = res_i.rd;
    assign rf.wr_data = res_i.data;

    // ------------------------------
    // Register storage
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `CORE_NR_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (rf.wr_en) begin
            regs_q[rf.wr_addr] <= rf.wr_data;
        end
    end

    // Read ports, x0 hardwired, same-cycle write forwarded
    always_comb begin : read_ports
        rf.rs1_data = regs_q[rf.rs1_addr];
        if (rf.wr_en && (rf.wr_addr == rf.rs1_addr)) begin
            rf.rs1_data = rf.wr_data;
        end
        if (rf.rs1_addr == '0) begin
            rf.rs1_data = '0;
        end

        rf.rs2_data = regs_q[rf.rs2_addr];
        if (rf.wr_en && (rf.wr_addr == rf.rs2_addr)) begin
            rf.rs2_data = rf.wr_data;
        end
        if (rf.rs2_addr == '0) begin
            rf.rs2_data = '0;
        end
    end

endmodule

`default_nettype wire
